// File: apb_uart_rx.f
src/uart_rx_pkg.sv
src/apb_uart_regs.sv
src/rx_framer.sv
src/rx_buffer.sv
src/apb_uart_rx.sv
dv/tb_apb_uart_rx.sv

// File: Makefile
# Verilator flow for the APB UART receiver

TOP       ?= tb_apb_uart_rx
FLIST     ?= apb_uart_rx.f
SEED      ?= 32'hc3612b17
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
FAIL_MSG  := Errors found
PASS_MSG  := No errors

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST) "-Gseed_init=$(SEED)"

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		"-Gseed_init=$(SEED)" -Mdir $(BUILD_DIR)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_apb_uart_rx.sv
// Testbench for the APB UART receiver
// Drives APB transfers and serial frames, keeps a small model of the
// receive status and checks every access cycle with assertions

module tb_apb_uart_rx
  import uart_rx_pkg::*;
#(
  parameter logic [31:0] seed_init = 32'hc3612b17
);

  timeunit 1ns;
  timeprecision 10ps;

  localparam int clk_period_ns    = 40;
  localparam int reset_cycles     = 4;
  localparam int bit_period_w     = 14;
  localparam int reset_bit_period = 100;
  // Sweep frames are size+2 bits long; three size 8 frames at period 10 after it
  localparam int sweep_clocks   = (5 + 7 + 8 + 3 * 2) * (10 + 50 + 200);
  localparam int extra_clocks   = 3 * (8 + 2) * 10;
  localparam int reg_allowance  = 1500;
  localparam int timeout_cycles = sweep_clocks + extra_clocks + reg_allowance;

  logic              tb_clk;
  logic              rst;
  logic              serial_in;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic              pslverr;

  // Expected bus response set in the setup cycle
  logic [data_w-1:0] exp_prdata;
  logic              exp_pslverr;
  // Model of the receive status
  logic [data_w-1:0] model_word;
  logic              model_ready;
  logic              model_overrun;
  logic              model_framing;
  int                cfg_size;

  integer seed;
  int     cycle_count = 0;
  int     periods [3];
  int     sizes [3];
  logic   frame_done;

  apb_uart_rx #(
    .bit_period_w     (bit_period_w),
    .reset_bit_period (reset_bit_period)
  ) apb_uart_rx_inst (
    .tb_clk    (tb_clk),
    .rst       (rst),
    .serial_in (serial_in),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr)
  );

  // End of frame marker from the framer
  assign frame_done = apb_uart_rx_inst.frame.done;

  always #(clk_period_ns / 2) tb_clk = ~tb_clk;

  // Cycle limit
  always @(posedge tb_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d clocks", timeout_cycles);
      $display("Errors found");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  //**********************************************************************
  // Bus checks
  //**********************************************************************
  task automatic report_mismatch(input string msg);
    $display("FAIL at %0d ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "Stopped at first mismatch");
  endtask

  // Access cycle response sampled at the edge that ends the transfer
  access_check: assert property (@(posedge tb_clk) disable iff (rst)
    (psel && penable) |-> ((prdata == exp_prdata) && (pslverr == exp_pslverr)))
    else report_mismatch($sformatf("addr %0d prdata %h pslverr %b, expected %h %b",
      $sampled(paddr), $sampled(prdata), $sampled(pslverr),
      $sampled(exp_prdata), $sampled(exp_pslverr)));

  // Bus outputs quiet outside access cycles
  idle_check: assert property (@(posedge tb_clk) disable iff (rst)
    !(psel && penable) |-> ((prdata == '0) && !pslverr))
    else report_mismatch("prdata or pslverr active outside an access cycle");

  //**********************************************************************
  // APB and serial drivers
  //**********************************************************************
  task automatic apb_transfer(input logic write, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] wdata,
                              input logic [data_w-1:0] exp_data, input logic exp_err);
    // Setup cycle
    @(negedge tb_clk);
    psel        = 1'b1;
    penable     = 1'b0;
    pwrite      = write;
    paddr       = addr;
    pwdata      = wdata;
    exp_prdata  = exp_data;
    exp_pslverr = exp_err;
    // Access cycle
    @(negedge tb_clk);
    penable = 1'b1;
    @(negedge tb_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp_data,
                          input logic exp_err);
    apb_transfer(1'b0, addr, '0, exp_data, exp_err);
  endtask

  // Writes never return read data
  task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                           input logic exp_err);
    apb_transfer(1'b1, addr, wdata, '0, exp_err);
  endtask

  task automatic set_line_config(input int period, input int size);
    apb_write(bit_cr0, 8'(period), 1'b0);
    apb_write(bit_cr1, 8'(period >> 8), 1'b0);
    apb_write(data_cr, 8'(size), 1'b0);
    cfg_size = size;
  endtask

  // Start bit, size bits LSB first, stop bit; returns once the frame is done
  task automatic send_frame(input logic [7:0] word, input int size, input int period,
                            input logic stop_val);
    logic seen;
    seen = 1'b0;
    @(negedge tb_clk);
    serial_in = 1'b0;
    repeat (period) @(negedge tb_clk);
    for (int i = 0; i < size; i++) begin
      serial_in = word[i];
      repeat (period) @(negedge tb_clk);
    end
    serial_in = stop_val;
    repeat (period) begin
      @(negedge tb_clk);
      if (frame_done) seen = 1'b1;
    end
    serial_in = 1'b1;
    while (!seen) begin
      @(negedge tb_clk);
      seen = frame_done;
    end
  endtask

  //**********************************************************************
  // Status model
  //**********************************************************************
  function automatic logic [7:0] size_mask(input int size);
    logic [7:0] m;
    m = '0;
    for (int i = 0; i < 8; i++) begin
      if (i < size) m[i] = 1'b1;
    end
    return m;
  endfunction

  // Good frame over an unread word is an overrun; bad stop keeps the word
  task automatic note_frame(input logic good, input logic [7:0] word);
    if (good) begin
      if (model_ready) model_overrun = 1'b1;
      model_ready = 1'b1;
      model_word  = word;
    end else begin
      model_framing = 1'b1;
    end
  endtask

  task automatic check_data_ready();
    apb_read(data_sr, {7'b0, model_ready}, 1'b0);
  endtask

  // Reading error status clears both flags
  task automatic check_errors();
    apb_read(error_sr, {6'b0, model_overrun, model_framing}, 1'b0);
    model_overrun = 1'b0;
    model_framing = 1'b0;
  endtask

  task automatic check_rx_data();
    apb_read(rx_data, model_word, 1'b0);
    model_ready = 1'b0;
  endtask

  //**********************************************************************
  // Stimulus
  //**********************************************************************
  initial begin
    int         rnd;
    logic [7:0] word;
    logic [7:0] word2;
    tb_clk        = 1'b0;
    rst           = 1'b1;
    serial_in     = 1'b1;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    exp_prdata    = '0;
    exp_pslverr   = 1'b0;
    model_word    = '0;
    model_ready   = 1'b0;
    model_overrun = 1'b0;
    model_framing = 1'b0;
    cfg_size      = 8;
    seed          = seed_init;
    periods       = '{10, 50, 200};
    sizes         = '{5, 7, 8};
    repeat (reset_cycles) @(negedge tb_clk);
    rst = 1'b0;

    // Reset values
    apb_read(bit_cr0, 8'(reset_bit_period), 1'b0);
    apb_read(bit_cr1, 8'(reset_bit_period >> 8), 1'b0);
    apb_read(data_cr, 8'd8, 1'b0);
    check_data_ready();
    check_errors();

    // Configuration read-back where bit_cr1 keeps only the existing bits
    apb_write(bit_cr0, 8'ha5, 1'b0);
    apb_read(bit_cr0, 8'ha5, 1'b0);
    apb_write(bit_cr1, 8'hff, 1'b0);
    apb_read(bit_cr1, 8'((1 << (bit_period_w - 8)) - 1), 1'b0);
    apb_write(data_cr, 8'd6, 1'b0);
    apb_read(data_cr, 8'd6, 1'b0);

    // Frame sweep over period and size
    foreach (periods[p]) begin
      foreach (sizes[s]) begin
        set_line_config(periods[p], sizes[s]);
        rnd  = $random(seed);
        word = rnd[7:0];
        send_frame(word, sizes[s], periods[p], 1'b1);
        note_frame(1'b1, word & size_mask(sizes[s]));
        check_data_ready();
        check_rx_data();
        check_data_ready();
      end
    end

    // Overrun as the second word replaces the first
    set_line_config(10, 8);
    rnd   = $random(seed);
    word  = rnd[7:0];
    word2 = rnd[15:8];
    send_frame(word, 8, 10, 1'b1);
    note_frame(1'b1, word);
    send_frame(word2, 8, 10, 1'b1);
    note_frame(1'b1, word2);
    check_errors();
    check_data_ready();
    check_rx_data();
    check_errors();

    // Framing error from a low stop bit
    rnd  = $random(seed);
    word = rnd[7:0];
    send_frame(word, 8, 10, 1'b0);
    note_frame(1'b0, word);
    check_errors();
    check_data_ready();

    // Illegal accesses each followed by a re-read
    apb_write(rx_data, ~model_word, 1'b1);
    check_rx_data();
    apb_write(data_sr, 8'h01, 1'b1);
    check_data_ready();
    check_errors();
    apb_read(3'd5, 8'h00, 1'b1);
    apb_write(3'd5, 8'h5a, 1'b1);
    apb_write(data_cr, 8'd4, 1'b1);
    apb_write(data_cr, 8'd9, 1'b1);
    apb_read(data_cr, 8'(cfg_size), 1'b0);

    @(negedge tb_clk);
    $display("No errors");
    $finish;
  end

endmodule

// File: src/apb_uart_rx.sv
// APB UART receiver top level
// Register block and serial framer side by side, with the receive
// buffer merging finished frames and software reads into status

module apb_uart_rx
  import uart_rx_pkg::*;
#(
  parameter int bit_period_w     = bit_period_w_default,
  parameter int reset_bit_period = 100
) (
  input  logic              tb_clk,
  input  logic              rst,
  input  logic              serial_in,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pslverr
);

  // Configuration to the framer
  rx_cfg_t    cfg;
  // Framer result, one per frame
  rx_frame_t  frame;
  // Held word and flags back to the read mux
  rx_status_t status;
  // Read side effects
  logic       rd_data_strobe;
  logic       rd_error_strobe;

  //********************************************************************
  // APB register block
  //********************************************************************
  apb_uart_regs #(
    .bit_period_w     (bit_period_w),
    .reset_bit_period (reset_bit_period)
  ) apb_uart_regs_inst (
    .tb_clk          (tb_clk),
    .rst             (rst),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pslverr         (pslverr),
    .status          (status),
    .cfg             (cfg),
    .rd_data_strobe  (rd_data_strobe),
    .rd_error_strobe (rd_error_strobe)
  );

  //********************************************************************
  // Serial side
  //********************************************************************
  rx_framer #(
    .bit_period_w (bit_period_w)
  ) rx_framer_inst (
    .tb_clk    (tb_clk),
    .rst       (rst),
    .serial_in (serial_in),
    .cfg       (cfg),
    .frame     (frame)
  );

  rx_buffer rx_buffer_inst (
    .tb_clk          (tb_clk),
    .rst             (rst),
    .frame           (frame),
    .rd_data_strobe  (rd_data_strobe),
    .rd_error_strobe (rd_error_strobe),
    .status          (status)
  );

endmodule

// File: src/rx_buffer.sv
// UART receive buffer
// Holds the last good word with data-ready, overrun and framing flags.
// Frames never wait; a new word over an unread one sets overrun

module rx_buffer
  import uart_rx_pkg::*;
(
  input  logic       tb_clk,
  input  logic       rst,
  input  rx_frame_t  frame,
  input  logic       rd_data_strobe,
  input  logic       rd_error_strobe,
  output rx_status_t status
);

  rx_status_t status_next;

  //********************************************************************
  // Flag update
  //********************************************************************
  always_comb begin
    status_next = status;
    // Software reads clear first
    if (rd_data_strobe) begin
      status_next.data_ready = 1'b0;
    end
    if (rd_error_strobe) begin
      status_next.overrun = 1'b0;
      status_next.framing = 1'b0;
    end
    // A finishing frame wins over a read on the same edge
    if (frame.done) begin
      if (frame.framing_err) begin
        // Bad stop bit, held word stays
        status_next.framing = 1'b1;
      end else begin
        // Unread word being replaced
        if (status.data_ready && !rd_data_strobe) begin
          status_next.overrun = 1'b1;
        end
        status_next.data_ready = 1'b1;
        status_next.data       = frame.data;
      end
    end
  end

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      status <= '0;
    end else begin
      status <= status_next;
    end
  end

endmodule

// File: src/rx_framer.sv
// UART receive framer
// Synchronizes the serial line, times bits from the falling edge of
// the start bit and samples each bit in its middle. LSB first, one
// start and one stop bit; one frame result per frame

module rx_framer
  import uart_rx_pkg::*;
#(
  parameter int bit_period_w = bit_period_w_default
) (
  input  logic      tb_clk,
  input  logic      rst,
  input  logic      serial_in,
  input  rx_cfg_t   cfg,
  output rx_frame_t frame
);

  localparam logic [bit_period_w-1:0] one_tick = 1;

  // Two-stage synchronizer and edge detect
  logic [1:0] sync_q;
  logic       line;
  logic       line_q;
  logic       fall;

  // FSM, bit timer and bit counter
  rx_state_e               state;
  logic [bit_period_w-1:0] timer;
  logic [2:0]              bit_cnt;
  logic                    last_bit;

  // Per-frame copy of the configuration and the word being built
  rx_cfg_t           frame_cfg;
  logic [data_w-1:0] rx_word;

  // Timer loads, one less than the wanted number of clocks
  logic [bit_period_w-1:0] half_load;
  logic [bit_period_w-1:0] period_load;

  assign line = sync_q[1];
  assign fall = line_q & ~line;

  // Half period from live config, frame has not latched it yet
  assign half_load   = (cfg.bit_period[bit_period_w-1:0] >> 1) - one_tick;
  assign period_load = frame_cfg.bit_period[bit_period_w-1:0] - one_tick;
  assign last_bit    = ({1'b0, bit_cnt} == (frame_cfg.data_size - 4'd1));

  //********************************************************************
  // Receive FSM
  //********************************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      // Line idles high
      sync_q  <= 2'b11;
      line_q  <= 1'b1;
      state   <= idle;
      timer   <= '0;
      bit_cnt <= '0;
      frame   <= '0;
    end else begin
      sync_q     <= {sync_q[0], serial_in};
      line_q     <= line;
      frame.done <= 1'b0;
      case (state)
        idle: begin
          if (fall) begin
            timer <= half_load;
            state <= start;
          end
        end
        start: begin
          if (timer == '0) begin
            // Middle of start bit; a glitch sends us back
            if (!line) begin
              timer   <= period_load;
              bit_cnt <= '0;
              state   <= data;
            end else begin
              state <= idle;
            end
          end else begin
            timer <= timer - one_tick;
          end
        end
        data: begin
          if (timer == '0) begin
            timer <= period_load;
            if (last_bit) begin
              state <= stop;
            end else begin
              bit_cnt <= bit_cnt + 3'd1;
            end
          end else begin
            timer <= timer - one_tick;
          end
        end
        stop: begin
          if (timer == '0) begin
            // Stop sample, result out on the next cycle
            frame.done        <= 1'b1;
            frame.data        <= rx_word;
            frame.framing_err <= ~line;
            state             <= idle;
          end else begin
            timer <= timer - one_tick;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  //********************************************************************
  // Data path
  //********************************************************************
  always_ff @(posedge tb_clk) begin
    if ((state == idle) && fall) begin
      frame_cfg <= cfg;
      // Upper bits stay zero for short sizes
      rx_word   <= '0;
    end else if ((state == data) && (timer == '0)) begin
      rx_word[bit_cnt] <= line;
    end
  end

endmodule

// File: src/apb_uart_regs.sv
// APB slave for the UART receiver
// Holds bit period and data size, returns status and configuration,
// flags illegal accesses with pslverr and leaves state untouched then.
// No wait states, so every transfer ends in its access cycle

module apb_uart_regs
  import uart_rx_pkg::*;
#(
  parameter int bit_period_w     = bit_period_w_default,
  parameter int reset_bit_period = 100
) (
  input  logic              tb_clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pslverr,
  input  rx_status_t        status,
  output rx_cfg_t           cfg,
  output logic              rd_data_strobe,
  output logic              rd_error_strobe
);

  // Configuration registers
  logic [bit_period_w-1:0] bit_period;
  logic [3:0]              data_size;

  // Access cycle decode
  logic            access;
  reg_addr_e       addr;
  logic            access_err;
  logic [data_w-1:0] rd_word;

  assign access = psel & penable;
  // Holes in the map still cast; they fall to the default arm
  assign addr   = reg_addr_e'(paddr);

  //********************************************************************
  // Read mux and error decode
  //********************************************************************
  always_comb begin
    rd_word    = '0;
    access_err = 1'b0;
    case (addr)
      data_sr: begin
        rd_word    = {{(data_w-1){1'b0}}, status.data_ready};
        access_err = pwrite;
      end
      error_sr: begin
        // Overrun in bit 1, framing in bit 0
        rd_word    = {{(data_w-2){1'b0}}, status.overrun, status.framing};
        access_err = pwrite;
      end
      bit_cr0: rd_word = bit_period[7:0];
      // Only the upper period bits that exist, zero above
      bit_cr1: rd_word = data_w'(bit_period[bit_period_w-1:8]);
      data_cr: begin
        rd_word    = {4'b0000, data_size};
        // Legal sizes are 5 to 8
        access_err = pwrite && ((pwdata < 8'd5) || (pwdata > 8'd8));
      end
      rx_data: begin
        rd_word    = status.data;
        access_err = pwrite;
      end
      default: access_err = 1'b1;
    endcase
  end

  // Bus outputs only live in the access cycle
  assign pslverr = access & access_err;
  assign prdata  = (access && !pwrite && !access_err) ? rd_word : '0;

  // Read side effects for the receive buffer
  assign rd_data_strobe  = access && !pwrite && (addr == rx_data);
  assign rd_error_strobe = access && !pwrite && (addr == error_sr);

  //********************************************************************
  // Configuration writes
  //********************************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      bit_period <= bit_period_w'(reset_bit_period);
      data_size  <= 4'd8;
    end else if (access && pwrite && !access_err) begin
      case (addr)
        bit_cr0: bit_period[7:0] <= pwdata;
        // Upper byte only keeps the bits the counter has
        bit_cr1: bit_period[bit_period_w-1:8] <= pwdata[bit_period_w-9:0];
        data_cr: data_size <= pwdata[3:0];
        default: ;
      endcase
    end
  end

  // Period widened to the struct field
  assign cfg.bit_period = bit_period_w_default'(bit_period);
  assign cfg.data_size  = data_size;

endmodule

// File: src/uart_rx_pkg.sv
// UART receiver shared definitions
// Register map, framer states and the structs passed between the
// register block, the serial framer and the receive buffer

package uart_rx_pkg;

  //********************************************************************
  // Widths
  //********************************************************************
  // APB address and data
  localparam int addr_w = 3;
  localparam int data_w = 8;
  // Bit period counter width unless the top overrides it
  localparam int bit_period_w_default = 14;

  //********************************************************************
  // Register map and states
  //********************************************************************
  // Byte-wide registers; 5 and 7 are holes
  typedef enum logic [addr_w-1:0] {
    data_sr  = 3'd0,
    error_sr = 3'd1,
    bit_cr0  = 3'd2,
    bit_cr1  = 3'd3,
    data_cr  = 3'd4,
    rx_data  = 3'd6
  } reg_addr_e;

  // Receive FSM
  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } rx_state_e;

  //********************************************************************
  // Structs
  //********************************************************************
  // Line configuration, register block to framer
  typedef struct packed {
    logic [bit_period_w_default-1:0] bit_period;
    logic [3:0]                      data_size;
  } rx_cfg_t;

  // One result per received frame
  typedef struct packed {
    logic              done;
    logic [data_w-1:0] data;
    logic              framing_err;
  } rx_frame_t;

  // Status seen by software
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              data_ready;
    logic              overrun;
    logic              framing;
  } rx_status_t;

endpackage
